/* files.f */
+incdir+logic
logic/starfield_pkg.sv
logic/video_timing.sv
logic/star_layer.sv
logic/star_rom_arbiter.sv
logic/star_mixer.sv
logic/starfield_top.sv
testbench/starfield_checker.sv
testbench/starfield_tb.sv

/* logic/star_layer.sv */
//**********************************************************
// star field layer
// scroll and flip, next tile prefetch over the shared rom
// port, twinkle counters and registered star pixel
//**********************************************************
`default_nettype none

`include "starfield_config.svh"

module star_layer #(
    parameter int LANE = 0
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        pxl_cen,
    input  wire starfield_pkg::dump_t  hdump,
    input  wire starfield_pkg::dump_t  vdump,
    input  wire                        hblank,
    input  wire                        vblank,
    input  wire                        flip,
    input  wire starfield_pkg::dump_t  hpos,
    input  wire starfield_pkg::dump_t  vpos,
    output logic                       req,
    output starfield_pkg::star_addr_t  req_addr,
    input  wire                        ok,
    input  wire starfield_pkg::star_word_t data,
    output starfield_pkg::star_pxl_t   star_pxl
);

    localparam int FRM_W = $clog2(`SF_TWINKLE_FRAMES);

    // hblank fetch points, first tile then second tile of the next line
    localparam starfield_pkg::dump_t FETCH_A = starfield_pkg::dump_t'(`SF_H_ACTIVE + 16);
    localparam starfield_pkg::dump_t FETCH_B = starfield_pkg::dump_t'(`SF_H_ACTIVE + 32);
    localparam starfield_pkg::dump_t V_LAST  = starfield_pkg::dump_t'(`SF_V_TOTAL - 1);

    starfield_pkg::dump_t      hraw;
    starfield_pkg::dump_t      heff;
    starfield_pkg::dump_t      vnext;
    starfield_pkg::dump_t      vline;
    starfield_pkg::dump_t      veff;
    starfield_pkg::star_byte_t rom_byte;
    starfield_pkg::pal_t       cur_pal;
    starfield_pkg::pal_t       nxt_pal;
    logic [4:0]                cur_pos;
    logic [4:0]                nxt_pos;
    logic [3:0]                col_raw;
    logic                      fetch_first;
    logic                      fetch_second;
    logic                      fetch_inline;
    logic                      do_fetch;
    logic                      swap_inline;
    logic [FRM_W-1:0]          fcnt;
    logic                      vbl_l;
    starfield_pkg::twinkle_t   cnt15;
    starfield_pkg::twinkle_t   cnt16;
    starfield_pkg::twinkle_t   level;
    logic                      hit;

    // raw scrolled x counts up, flip inverts it
    assign hraw = hpos + hdump;
    assign heff = hraw ^ {9{flip}};

    // in hblank the fetches are for the line after this one
    assign vnext = (vdump == V_LAST) ? '0 : vdump + 1'b1;
    assign vline = hblank ? vnext : vdump;
    assign veff  = (vpos + vline) ^ {9{flip}};

    assign fetch_first  = hdump == FETCH_A;
    assign fetch_second = hdump == FETCH_B;
    // halfway through a tile, in flipped coordinates too
    assign fetch_inline = !hblank && heff[4:0] == 5'd16;
    assign do_fetch     = fetch_first || fetch_second || fetch_inline;

    // tile ends on the raw count whatever the flip
    assign swap_inline = !hblank && hraw[4:0] == 5'd31;

    // tile column ahead of the beam, in raw order
    assign col_raw = hblank ? (hpos[8:5] + {3'd0, fetch_second}) : (hraw[8:5] + 4'd1);

    assign rom_byte = data[LANE*8 +: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= 1'b0;
        end else begin
            req <= pxl_cen && do_fetch;
        end
    end

    // address held until the next request
    always_ff @(posedge clk) begin
        if (pxl_cen && do_fetch) begin
            req_addr <= {col_raw ^ {4{flip}}, veff};
        end
    end

    // next tile slot, position stored already flipped
    always_ff @(posedge clk) begin
        if (ok) begin
            nxt_pal <= rom_byte[7:5];
            nxt_pos <= rom_byte[4:0] ^ {5{flip}};
        end
    end

    // current tile, loaded at the boundary or in hblank for the line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_pal <= '0;
            cur_pos <= 5'd15;
        end else if (pxl_cen && (swap_inline || fetch_second)) begin
            cur_pal <= nxt_pal;
            cur_pos <= nxt_pos;
        end
    end

    // frame count on vblank rise, twinkle step once per period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vbl_l <= 1'b0;
            fcnt  <= '0;
            cnt15 <= '0;
            cnt16 <= '0;
        end else if (pxl_cen) begin
            vbl_l <= vblank;
            if (vblank && !vbl_l) begin
                if (fcnt == FRM_W'(`SF_TWINKLE_FRAMES - 1)) begin
                    fcnt  <= '0;
                    // mod 15 never reaches the see-through value
                    cnt15 <= (cnt15 == 4'd14) ? 4'd0 : cnt15 + 1'b1;
                    cnt16 <= cnt16 + 1'b1;
                end else begin
                    fcnt <= fcnt + 1'b1;
                end
            end
        end
    end

    // groups 4 to 7 take mod 15, groups 0 to 3 mod 16
    assign level = cur_pal[2] ? cnt15 : cnt16;
    assign hit   = heff[4:0] == cur_pos && cur_pos != 5'd15 && level != 4'hf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            star_pxl <= '{pal_id: '0, intensity: 4'hf};
        end else if (pxl_cen) begin
            if (hit) begin
                star_pxl <= '{pal_id: cur_pal, intensity: level};
            end else begin
                star_pxl <= '{pal_id: '0, intensity: 4'hf};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/star_mixer.sv */
//**********************************************************
// star mixer
// layer 1 over layer 0, transparent under blanking,
// registered output pixel
//**********************************************************
`default_nettype none

module star_mixer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        pxl_cen,
    input  wire                        hblank,
    input  wire                        vblank,
    input  wire starfield_pkg::star_pxl_t layer0,
    input  wire starfield_pkg::star_pxl_t layer1,
    output starfield_pkg::star_pxl_t   pxl
);

    // blanking delayed to match the registered layer pixels
    logic blank_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_d <= 1'b1;
        end else if (pxl_cen) begin
            blank_d <= hblank | vblank;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '{pal_id: '0, intensity: 4'hf};
        end else if (pxl_cen) begin
            if (blank_d) begin
                pxl <= '{pal_id: '0, intensity: 4'hf};
            end else if (layer1.intensity != 4'hf) begin
                // front layer has a star here
                pxl <= layer1;
            end else begin
                pxl <= layer0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/star_rom_arbiter.sv */
//**********************************************************
// star rom arbiter
// two layer fetch requests served one at a time
// on the single star rom port
//**********************************************************
`default_nettype none

module star_rom_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req0,
    input  wire starfield_pkg::star_addr_t addr0,
    input  wire                          req1,
    input  wire starfield_pkg::star_addr_t addr1,
    output logic                         ok0,
    output logic                         ok1,
    output starfield_pkg::star_word_t    data,
    output starfield_pkg::star_addr_t    rom_addr,
    output logic                         rom_cs,
    input  wire starfield_pkg::star_word_t rom_data,
    input  wire                          rom_ok
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

    arb_state_t state;
    logic       pend0;
    logic       pend1;
    logic       want0;
    logic       want1;
    logic       owner;

    // a strobe counts in the same cycle it arrives
    assign want0 = pend0 | req0;
    assign want1 = pend1 | req1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ARB_IDLE;
            pend0  <= 1'b0;
            pend1  <= 1'b0;
            owner  <= 1'b0;
            rom_cs <= 1'b0;
            ok0    <= 1'b0;
            ok1    <= 1'b0;
        end else begin
            ok0   <= 1'b0;
            ok1   <= 1'b0;
            pend0 <= want0;
            pend1 <= want1;
            case (state)
                ARB_IDLE: begin
                    // layer 0 first on a tie
                    if (want0) begin
                        owner  <= 1'b0;
                        pend0  <= 1'b0;
                        rom_cs <= 1'b1;
                        state  <= ARB_BUSY;
                    end else if (want1) begin
                        owner  <= 1'b1;
                        pend1  <= 1'b0;
                        rom_cs <= 1'b1;
                        state  <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    // one idle cycle after each access, the waiting
                    // layer is picked before the served one can ask again
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        ok0    <= !owner;
                        ok1    <= owner;
                        state  <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // address captured at dispatch, word captured on the answer
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && (want0 || want1)) begin
            rom_addr <= want0 ? addr0 : addr1;
        end
        if (rom_ok) begin
            data <= rom_data;
        end
    end

endmodule

`default_nettype wire

/* logic/starfield_config.svh */
//**********************************************************
// star field build constants
// video timing totals, pixel divider, rom geometry and
// twinkle rate shared by the rtl and the testbench
//**********************************************************
`ifndef STARFIELD_CONFIG_SVH
`define STARFIELD_CONFIG_SVH

// clocks per pixel enable
`define SF_PXL_DIV 2

// horizontal line, active part then blanking
`define SF_H_ACTIVE 64
`define SF_H_TOTAL 112

// vertical frame in lines
`define SF_V_ACTIVE 16
`define SF_V_TOTAL 24

// frames between twinkle steps
`define SF_TWINKLE_FRAMES 16

// worst case rom answer time, in pixel enables
`define SF_ROM_MAX_LAT 6

// coordinate and star rom widths
`define SF_DUMP_W 9
`define SF_ROM_AW 13
`define SF_ROM_DW 32

`endif

/* logic/starfield_pkg.sv */
//**********************************************************
// star field shared types
// coordinates, rom address and data words, star pixel
//**********************************************************
`default_nettype none

`include "starfield_config.svh"

package starfield_pkg;

    // screen position or scroll value
    typedef logic [`SF_DUMP_W-1:0] dump_t;

    // {tile column, effective line}
    typedef logic [`SF_ROM_AW-1:0] star_addr_t;

    // four byte lanes, one per star field
    typedef logic [`SF_ROM_DW-1:0] star_word_t;

    // top three bits palette group, low five bits position
    typedef logic [7:0] star_byte_t;

    // star brightness, 15 is see-through
    typedef logic [3:0] twinkle_t;

    typedef logic [2:0] pal_t;

    // one pixel of a star layer
    typedef struct packed {
        pal_t     pal_id;
        twinkle_t intensity;
    } star_pxl_t;

endpackage

`default_nettype wire

/* logic/starfield_top.sv */
//**********************************************************
// star field top
// timing, two star layers, rom arbiter and mixer
//**********************************************************
`default_nettype none

module starfield_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flip,
    input  wire starfield_pkg::dump_t    hpos0,
    input  wire starfield_pkg::dump_t    vpos0,
    input  wire starfield_pkg::dump_t    hpos1,
    input  wire starfield_pkg::dump_t    vpos1,
    output starfield_pkg::star_addr_t    rom_addr,
    output logic                         rom_cs,
    input  wire starfield_pkg::star_word_t rom_data,
    input  wire                          rom_ok,
    output starfield_pkg::dump_t         hdump,
    output starfield_pkg::dump_t         vdump,
    output logic                         vblank,
    output starfield_pkg::star_pxl_t     pxl
);

    logic                      pxl_cen;
    logic                      hblank;
    logic                      req0;
    logic                      req1;
    logic                      ok0;
    logic                      ok1;
    starfield_pkg::star_addr_t addr0;
    starfield_pkg::star_addr_t addr1;
    starfield_pkg::star_word_t rom_word;
    starfield_pkg::star_pxl_t  pxl0;
    starfield_pkg::star_pxl_t  pxl1;

    video_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .hblank  (hblank),
        .vblank  (vblank)
    );

    // back field, rom byte lane 0
    star_layer #(.LANE(0)) u_layer0 (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .hblank   (hblank),
        .vblank   (vblank),
        .flip     (flip),
        .hpos     (hpos0),
        .vpos     (vpos0),
        .req      (req0),
        .req_addr (addr0),
        .ok       (ok0),
        .data     (rom_word),
        .star_pxl (pxl0)
    );

    // front field, rom byte lane 1
    star_layer #(.LANE(1)) u_layer1 (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .hblank   (hblank),
        .vblank   (vblank),
        .flip     (flip),
        .hpos     (hpos1),
        .vpos     (vpos1),
        .req      (req1),
        .req_addr (addr1),
        .ok       (ok1),
        .data     (rom_word),
        .star_pxl (pxl1)
    );

    star_rom_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .req0     (req0),
        .addr0    (addr0),
        .req1     (req1),
        .addr1    (addr1),
        .ok0      (ok0),
        .ok1      (ok1),
        .data     (rom_word),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    star_mixer u_mixer (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hblank  (hblank),
        .vblank  (vblank),
        .layer0  (pxl0),
        .layer1  (pxl1),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

/* logic/video_timing.sv */
//**********************************************************
// video timing generator
// pixel enable, horizontal and vertical dump counters
// and blanking levels
//**********************************************************
`default_nettype none

`include "starfield_config.svh"

module video_timing (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 pxl_cen,
    output starfield_pkg::dump_t hdump,
    output starfield_pkg::dump_t vdump,
    output logic                 hblank,
    output logic                 vblank
);

    // wide enough to hold the divider count
    localparam int DIV_W = $clog2(`SF_PXL_DIV + 1);

    localparam starfield_pkg::dump_t H_LAST   = starfield_pkg::dump_t'(`SF_H_TOTAL - 1);
    localparam starfield_pkg::dump_t V_LAST   = starfield_pkg::dump_t'(`SF_V_TOTAL - 1);
    localparam starfield_pkg::dump_t H_ACTIVE = starfield_pkg::dump_t'(`SF_H_ACTIVE);
    localparam starfield_pkg::dump_t V_ACTIVE = starfield_pkg::dump_t'(`SF_V_ACTIVE);

    logic [DIV_W-1:0] div_cnt;
    logic             div_last;

    // pixel divider
    assign div_last = div_cnt == DIV_W'(`SF_PXL_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_last) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // single clock pulse on the last divider count
    assign pxl_cen = div_last;

    // dump counters, vertical steps at the end of each line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == H_LAST) begin
                hdump <= '0;
                if (vdump == V_LAST) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // blanking straight from the counters
    // so it lines up with hdump and vdump
    assign hblank = hdump >= H_ACTIVE;
    assign vblank = vdump >= V_ACTIVE;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the star field testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f files.f \
    --top-module starfield_tb \
    --Mdir obj_dir \
    -o starfield_sim

./obj_dir/starfield_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* testbench/starfield_checker.sv */
//**********************************************************
// star field protocol checker
// rom port handshake, pixel enable and blanking rules
//**********************************************************
`default_nettype none

`include "starfield_config.svh"

module starfield_checker (
    input wire                           clk,
    input wire                           rst,
    input wire                           pxl_cen,
    input wire                           hblank,
    input wire                           vblank,
    input wire                           rom_cs,
    input wire                           rom_ok,
    input wire starfield_pkg::star_pxl_t pxl
);

    localparam int LAT_CLKS = `SF_ROM_MAX_LAT * `SF_PXL_DIV;

    int   cs_wait;
    logic blank_d1;
    logic blank_d2;

    // clocks spent waiting on the rom
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_wait <= 0;
        end else if (rom_cs && !rom_ok) begin
            cs_wait <= cs_wait + 1;
        end else begin
            cs_wait <= 0;
        end
    end

    // blanking two enables back to line up with pxl
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_d1 <= 1'b1;
            blank_d2 <= 1'b1;
        end else if (pxl_cen) begin
            blank_d1 <= hblank | vblank;
            blank_d2 <= blank_d1;
        end
    end

    a_cs_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(rom_cs) |-> $past(rom_ok))
        else $error("rom_cs dropped before rom_ok");

    a_rom_lat: assert property (@(posedge clk) disable iff (rst)
        cs_wait <= LAT_CLKS)
        else $error("rom_ok later than the rom latency bound");

    a_blank: assert property (@(posedge clk) disable iff (rst)
        blank_d2 |-> (pxl.intensity == 4'hf && pxl.pal_id == 3'd0))
        else $error("visible pixel under blanking");

    a_cen: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen)
        else $error("pxl_cen longer than one clock");

endmodule

bind starfield_top starfield_checker i_checker (
    .clk     (clk),
    .rst     (rst),
    .pxl_cen (pxl_cen),
    .hblank  (hblank),
    .vblank  (vblank),
    .rom_cs  (rom_cs),
    .rom_ok  (rom_ok),
    .pxl     (pxl)
);

`default_nettype wire

/* testbench/starfield_tb.sv */
//**********************************************************
// star field testbench
// rom model, scroll and flip stimulus, reference pixel
// model and per pixel compare against the top level
//**********************************************************
`default_nettype none

`include "starfield_config.svh"

module starfield_tb;

    localparam int FRAME_CLKS   = `SF_H_TOTAL * `SF_V_TOTAL * `SF_PXL_DIV;
    // warm up frame plus the six tests
    localparam int TOTAL_FRAMES = 1 + 1 + 3 + 2 + 34 + 2 + 2;
    localparam int CYCLE_LIMIT  = (TOTAL_FRAMES + 3) * FRAME_CLKS;

    // one observed screen position with the stimulus that produced it
    typedef struct packed {
        logic                 flip;
        starfield_pkg::dump_t hpos0;
        starfield_pkg::dump_t vpos0;
        starfield_pkg::dump_t hpos1;
        starfield_pkg::dump_t vpos1;
        starfield_pkg::dump_t h;
        starfield_pkg::dump_t v;
        int                   frames;
    } sample_t;

    logic                      clk;
    logic                      rst;
    logic                      flip;
    starfield_pkg::dump_t      hpos0;
    starfield_pkg::dump_t      vpos0;
    starfield_pkg::dump_t      hpos1;
    starfield_pkg::dump_t      vpos1;
    starfield_pkg::star_addr_t rom_addr;
    logic                      rom_cs;
    starfield_pkg::star_word_t rom_data;
    logic                      rom_ok;
    starfield_pkg::dump_t      hdump;
    starfield_pkg::dump_t      vdump;
    logic                      vblank;
    starfield_pkg::star_pxl_t  pxl;

    starfield_pkg::star_word_t rom_mem [0:8191];
    int                        wait_cnt;
    int                        lat;
    logic                      max_lat;
    int                        cycles;
    int                        frames;
    int                        checks;
    int                        errors;
    int                        overlaps;
    int                        tw_min;
    int                        tw_max;
    logic                      tw_on;
    logic                      check_on;
    logic                      vbl_last;
    starfield_pkg::dump_t      h_last;
    sample_t                   hist0;
    sample_t                   hist1;
    int                        hist_cnt;

    starfield_top i_starfield_top (
        .clk      (clk),
        .rst      (rst),
        .flip     (flip),
        .hpos0    (hpos0),
        .vpos0    (vpos0),
        .hpos1    (hpos1),
        .vpos1    (vpos1),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .hdump    (hdump),
        .vdump    (vdump),
        .vblank   (vblank),
        .pxl      (pxl)
    );

    always #2 clk = ~clk;

    // expected pixel of one star field
    function automatic starfield_pkg::star_pxl_t layer_ref(input int lane, input logic fl,
            input starfield_pkg::dump_t hpos, input starfield_pkg::dump_t vpos,
            input starfield_pkg::dump_t h, input starfield_pkg::dump_t v, input int frm);
        starfield_pkg::dump_t      heff;
        starfield_pkg::dump_t      veff;
        starfield_pkg::star_byte_t sbyte;
        logic [4:0]                pos;
        starfield_pkg::twinkle_t   lvl;
        int                        steps;
        heff  = hpos + h;
        heff  = heff ^ {9{fl}};
        veff  = vpos + v;
        veff  = veff ^ {9{fl}};
        sbyte = rom_mem[{heff[8:5], veff}][lane*8 +: 8];
        pos   = sbyte[4:0] ^ {5{fl}};
        steps = frm / `SF_TWINKLE_FRAMES;
        // upper palette groups cycle mod 15, lower ones mod 16
        lvl = sbyte[7] ? starfield_pkg::twinkle_t'(steps % 15)
                       : starfield_pkg::twinkle_t'(steps % 16);
        if (heff[4:0] == pos && pos != 5'd15 && lvl != 4'hf) begin
            layer_ref = '{pal_id: sbyte[7:5], intensity: lvl};
        end else begin
            layer_ref = '{pal_id: 3'd0, intensity: 4'hf};
        end
    endfunction

    // priority and blanking on top of the two fields
    function automatic starfield_pkg::star_pxl_t pixel_ref(input sample_t s);
        starfield_pkg::star_pxl_t l0;
        starfield_pkg::star_pxl_t l1;
        l0 = layer_ref(0, s.flip, s.hpos0, s.vpos0, s.h, s.v, s.frames);
        l1 = layer_ref(1, s.flip, s.hpos1, s.vpos1, s.h, s.v, s.frames);
        if (int'(s.h) >= `SF_H_ACTIVE || int'(s.v) >= `SF_V_ACTIVE) begin
            pixel_ref = '{pal_id: 3'd0, intensity: 4'hf};
        end else if (l1.intensity != 4'hf) begin
            pixel_ref = l1;
        end else begin
            pixel_ref = l0;
        end
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // rom answers 1 to max latency pixel enables after rom_cs
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 0;
        end else begin
            rom_ok <= 1'b0;
            if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
                if (wait_cnt == 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_mem[rom_addr];
                end
            end else if (rom_cs && !rom_ok) begin
                lat = max_lat ? `SF_ROM_MAX_LAT : $urandom_range(`SF_ROM_MAX_LAT, 1);
                wait_cnt <= lat * `SF_PXL_DIV - 1;
            end
        end
    end

    // compare once per new hdump value
    always @(posedge clk) begin
        sample_t                  cur;
        starfield_pkg::star_pxl_t exp;
        starfield_pkg::star_pxl_t l0;
        starfield_pkg::star_pxl_t l1;
        int                       f_now;
        if (rst) begin
            h_last   <= '1;
            vbl_last <= 1'b0;
            frames   <= 0;
            hist_cnt <= 0;
        end else if (hdump != h_last) begin
            h_last   <= hdump;
            vbl_last <= vblank;
            f_now = frames;
            if (vblank && !vbl_last) begin
                f_now = frames + 1;
            end
            frames <= f_now;
            cur = '{flip: flip, hpos0: hpos0, vpos0: vpos0, hpos1: hpos1, vpos1: vpos1,
                    h: hdump, v: vdump, frames: f_now};
            // pxl now shows the position seen two enables ago
            if (check_on && hist_cnt >= 2) begin
                exp = pixel_ref(hist1);
                check_val("pixel", int'(pxl), int'(exp));
                l0 = layer_ref(0, hist1.flip, hist1.hpos0, hist1.vpos0, hist1.h, hist1.v,
                               hist1.frames);
                l1 = layer_ref(1, hist1.flip, hist1.hpos1, hist1.vpos1, hist1.h, hist1.v,
                               hist1.frames);
                if (exp.intensity != 4'hf && l0.intensity != 4'hf && l1.intensity != 4'hf) begin
                    overlaps = overlaps + 1;
                end
                if (tw_on && exp.intensity != 4'hf && !exp.pal_id[2]) begin
                    if (int'(pxl.intensity) < tw_min) begin
                        tw_min = int'(pxl.intensity);
                    end
                    if (int'(pxl.intensity) > tw_max) begin
                        tw_max = int'(pxl.intensity);
                    end
                end
            end
            hist1 <= hist0;
            hist0 <= cur;
            hist_cnt <= hist_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) begin
            @(posedge clk);
        end
    endtask

    // called on a rising edge inside vblank
    task automatic set_scroll(input logic fl, input logic rnd, input logic same);
        starfield_pkg::dump_t a;
        starfield_pkg::dump_t b;
        starfield_pkg::dump_t c;
        starfield_pkg::dump_t d;
        a = rnd ? starfield_pkg::dump_t'($urandom) : '0;
        b = rnd ? starfield_pkg::dump_t'($urandom) : '0;
        c = rnd ? starfield_pkg::dump_t'($urandom) : '0;
        d = rnd ? starfield_pkg::dump_t'($urandom) : '0;
        flip  <= fl;
        hpos0 <= a;
        vpos0 <= b;
        hpos1 <= same ? a : c;
        vpos1 <= same ? b : d;
    endtask

    task automatic run_test(input int num, input string name, input int n_frames,
            input logic fl, input logic rnd, input logic same, input logic maxl);
        int err_start;
        int chk_start;
        err_start = errors;
        chk_start = checks;
        max_lat <= maxl;
        for (int i = 0; i < n_frames; i++) begin
            set_scroll(fl, rnd, same);
            wait_frames(1);
        end
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - chk_start, errors - err_start);
    endtask

    task automatic fill_rom();
        starfield_pkg::star_word_t w;
        int                        r;
        for (int i = 0; i < 8192; i++) begin
            w = $urandom;
            for (int k = 0; k < 4; k++) begin
                r = $urandom_range(7, 0);
                if (r == 0) begin
                    w[k*8 +: 5] = 5'd15;
                end else if (r == 1) begin
                    w[k*8 + 7] = 1'b1;
                end
            end
            // same position in both fields now and then
            if ($urandom_range(7, 0) == 0) begin
                w[12:8] = w[4:0];
            end
            rom_mem[i] = w;
        end
    endtask

    initial begin
        void'($urandom(92));
        clk      = 1'b0;
        rst      = 1'b1;
        flip     = 1'b0;
        hpos0    = '0;
        vpos0    = '0;
        hpos1    = '0;
        vpos1    = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        max_lat  = 1'b0;
        cycles   = 0;
        checks   = 0;
        errors   = 0;
        overlaps = 0;
        tw_min   = 99;
        tw_max   = -1;
        tw_on    = 1'b0;
        check_on = 1'b0;
        fill_rom();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // first frame after reset starts without a prefetched line
        wait_frames(1);
        check_on <= 1'b1;
        run_test(1, "no scroll", 1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test(2, "random scroll", 3, 1'b0, 1'b1, 1'b0, 1'b0);
        run_test(3, "flip", 2, 1'b1, 1'b1, 1'b0, 1'b0);
        tw_on <= 1'b1;
        run_test(4, "twinkle", 34, 1'b0, 1'b0, 1'b0, 1'b0);
        tw_on <= 1'b0;
        check_val("twinkle steps seen", int'(tw_max - tw_min >= 2), 1);
        overlaps = 0;
        run_test(5, "priority", 2, 1'b0, 1'b1, 1'b1, 1'b0);
        check_val("overlapping stars seen", int'(overlaps > 0), 1);
        run_test(6, "max rom latency", 2, 1'b0, 1'b1, 1'b1, 1'b1);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
